// ==== verilog/xl_switch_pkg.sv ====
package xl_switch_pkg;

    // stream and gmii byte width
    localparam int DATA_W = 8;
    typedef logic [DATA_W-1:0] byte_t;

    // frame fifo sizing, 256 bytes per source
    localparam int FIFO_ADDR_W = 8;
    localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_W;

    // per-source transmit frame counters
    localparam int CNT_W = 16;
    typedef logic [CNT_W-1:0] frame_count_t;

    // ethernet framing on the wire
    localparam int PREAMBLE_LEN = 7;
    localparam byte_t ETH_PREAMBLE = 8'h55;
    localparam byte_t ETH_SFD = 8'hD5;
    // minimum idle cycles between two bursts
    localparam int IFG_CYCLES = 12;

    // processor gmii receiver
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DROP
    } rx_state_t;

    // phy gmii transmitter
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_IFG
    } tx_state_t;

    // arbiter inputs
    typedef enum logic {
        SRC_PS,
        SRC_CS
    } source_t;

endpackage

// ==== verilog/gmii_frame_rx.sv ====
`timescale 1ns/1ps

module gmii_frame_rx (
    input  logic                 clk_int,
    input  logic                 rst_int,
    input  xl_switch_pkg::byte_t gmii_rxd,
    input  logic                 gmii_rx_dv,
    input  logic                 gmii_rx_er,
    output xl_switch_pkg::byte_t data,
    output logic                 valid,
    output logic                 last,
    output logic                 user
);

    xl_switch_pkg::rx_state_t state;
    // one byte kept back, last is only known when dv falls
    xl_switch_pkg::byte_t hold;
    logic hold_valid;
    // sticky tx_er over the whole frame
    logic err;

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state <= xl_switch_pkg::RX_IDLE;
            hold_valid <= 1'b0;
            err <= 1'b0;
            valid <= 1'b0;
            last <= 1'b0;
            user <= 1'b0;
        end else begin
            // output is a single-cycle strobe per byte
            valid <= 1'b0;
            last <= 1'b0;
            user <= 1'b0;
            case (state)
                xl_switch_pkg::RX_IDLE: begin
                    err <= gmii_rx_er;
                    if (gmii_rx_dv) begin
                        if (gmii_rxd == xl_switch_pkg::ETH_SFD) begin
                            state <= xl_switch_pkg::RX_DATA;
                        end else if (gmii_rxd == xl_switch_pkg::ETH_PREAMBLE) begin
                            state <= xl_switch_pkg::RX_PREAMBLE;
                        end else begin
                            state <= xl_switch_pkg::RX_DROP;
                        end
                    end
                end
                xl_switch_pkg::RX_PREAMBLE: begin
                    err <= err | gmii_rx_er;
                    // frame ended before sfd, nothing emitted
                    if (!gmii_rx_dv) begin
                        state <= xl_switch_pkg::RX_IDLE;
                    end else if (gmii_rxd == xl_switch_pkg::ETH_SFD) begin
                        state <= xl_switch_pkg::RX_DATA;
                    end else if (gmii_rxd != xl_switch_pkg::ETH_PREAMBLE) begin
                        state <= xl_switch_pkg::RX_DROP;
                    end
                end
                xl_switch_pkg::RX_DATA: begin
                    data <= hold;
                    valid <= hold_valid;
                    if (gmii_rx_dv) begin
                        // push new byte in, previous one goes out
                        err <= err | gmii_rx_er;
                        hold <= gmii_rxd;
                        hold_valid <= 1'b1;
                    end else begin
                        // dv fell, held byte closes the frame
                        last <= hold_valid;
                        user <= hold_valid & err;
                        hold_valid <= 1'b0;
                        state <= xl_switch_pkg::RX_IDLE;
                    end
                end
                xl_switch_pkg::RX_DROP: begin
                    // garbage before sfd, wait for dv low
                    if (!gmii_rx_dv) begin
                        state <= xl_switch_pkg::RX_IDLE;
                    end
                end
                default: state <= xl_switch_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo #(
    // writer cannot be stalled, so a full fifo always drops the frame
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic                 clk_int,
    input  logic                 rst_int,
    input  xl_switch_pkg::byte_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 in_last,
    input  logic                 in_user,
    output xl_switch_pkg::byte_t out_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 out_last,
    output logic                 overflow,
    output logic                 bad_frame,
    output logic                 good_frame
);

    // extra msb tells full from empty
    typedef logic [xl_switch_pkg::FIFO_ADDR_W:0] ptr_t;

    // each entry is {last, byte}
    logic [xl_switch_pkg::DATA_W:0] mem [xl_switch_pkg::FIFO_DEPTH];
    logic [xl_switch_pkg::DATA_W:0] rd_entry;

    ptr_t wr_ptr;
    // wr_ptr as of the last good frame, reader stops here
    ptr_t commit_ptr;
    ptr_t rd_ptr;
    // current frame overflowed, swallow the rest of it
    logic drop;

    logic full;
    logic has_frame;
    logic accept;
    logic wr_en;

    assign full = (wr_ptr ^ rd_ptr) == ptr_t'(xl_switch_pkg::FIFO_DEPTH);
    assign has_frame = commit_ptr != rd_ptr;

    // only stall when a committed frame can still drain
    assign in_ready = DROP_WHEN_FULL || !full || drop || !has_frame;
    assign accept = in_valid && in_ready;
    assign wr_en = accept && !drop && !full;

    always_ff @(posedge clk_int) begin
        if (wr_en) begin
            mem[wr_ptr[xl_switch_pkg::FIFO_ADDR_W-1:0]] <= {in_last, in_data};
        end
    end

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            wr_ptr <= '0;
            commit_ptr <= '0;
            rd_ptr <= '0;
            drop <= 1'b0;
            overflow <= 1'b0;
            bad_frame <= 1'b0;
            good_frame <= 1'b0;
        end else begin
            overflow <= 1'b0;
            bad_frame <= 1'b0;
            good_frame <= 1'b0;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // accepted but not stored, frame is lost
            if (accept && !wr_en) begin
                drop <= 1'b1;
            end
            if (accept && in_last) begin
                drop <= 1'b0;
                if (drop || full) begin
                    wr_ptr <= commit_ptr;
                    overflow <= 1'b1;
                end else if (in_user) begin
                    // bad frame, roll back
                    wr_ptr <= commit_ptr;
                    bad_frame <= 1'b1;
                end else begin
                    commit_ptr <= wr_ptr + 1'b1;
                    good_frame <= 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // read side sees committed bytes only
    assign rd_entry = mem[rd_ptr[xl_switch_pkg::FIFO_ADDR_W-1:0]];
    assign out_valid = has_frame;
    assign out_data = rd_entry[xl_switch_pkg::DATA_W-1:0];
    assign out_last = rd_entry[xl_switch_pkg::DATA_W];

endmodule

// ==== verilog/frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter (
    input  logic                        clk_int,
    input  logic                        rst_int,
    input  xl_switch_pkg::byte_t        ps_data,
    input  logic                        ps_valid,
    output logic                        ps_ready,
    input  logic                        ps_last,
    input  xl_switch_pkg::byte_t        cs_data,
    input  logic                        cs_valid,
    output logic                        cs_ready,
    input  logic                        cs_last,
    output xl_switch_pkg::byte_t        out_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic                        out_last,
    output xl_switch_pkg::frame_count_t ps_frame_count,
    output xl_switch_pkg::frame_count_t cs_frame_count
);

    xl_switch_pkg::source_t grant;
    xl_switch_pkg::source_t last_src;
    xl_switch_pkg::source_t pick;
    // grant is locked for a whole frame
    logic busy;
    logic sel_cs;
    logic frame_done;

    // round robin, the source not served last wins a tie
    always_comb begin
        if (ps_valid && cs_valid) begin
            pick = (last_src == xl_switch_pkg::SRC_PS) ? xl_switch_pkg::SRC_CS
                                                       : xl_switch_pkg::SRC_PS;
        end else if (cs_valid) begin
            pick = xl_switch_pkg::SRC_CS;
        end else begin
            pick = xl_switch_pkg::SRC_PS;
        end
    end

    // mux straight through to the granted source
    assign sel_cs = grant == xl_switch_pkg::SRC_CS;
    assign out_data = sel_cs ? cs_data : ps_data;
    assign out_last = sel_cs ? cs_last : ps_last;
    assign out_valid = busy && (sel_cs ? cs_valid : ps_valid);
    assign ps_ready = busy && !sel_cs && out_ready;
    assign cs_ready = busy && sel_cs && out_ready;

    assign frame_done = out_valid && out_ready && out_last;

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            busy <= 1'b0;
            grant <= xl_switch_pkg::SRC_PS;
            // ps goes first on the first tie
            last_src <= xl_switch_pkg::SRC_CS;
            ps_frame_count <= '0;
            cs_frame_count <= '0;
        end else if (!busy) begin
            if (ps_valid || cs_valid) begin
                busy <= 1'b1;
                grant <= pick;
            end
        end else if (frame_done) begin
            busy <= 1'b0;
            last_src <= grant;
            if (sel_cs) begin
                cs_frame_count <= cs_frame_count + 1'b1;
            end else begin
                ps_frame_count <= ps_frame_count + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/gmii_frame_tx.sv ====
`timescale 1ns/1ps

module gmii_frame_tx (
    input  logic                 clk_int,
    input  logic                 rst_int,
    input  xl_switch_pkg::byte_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 in_last,
    output xl_switch_pkg::byte_t gmii_txd,
    output logic                 gmii_tx_en
);

    // shared by preamble and ifg, sized for the larger
    typedef logic [$clog2(xl_switch_pkg::IFG_CYCLES + 1)-1:0] cnt_t;

    xl_switch_pkg::tx_state_t state;
    cnt_t cnt;

    // bytes pulled only while data goes on the wire
    assign in_ready = state == xl_switch_pkg::TX_DATA;

    always_ff @(posedge clk_int) begin
        if (rst_int) begin
            state <= xl_switch_pkg::TX_IDLE;
            cnt <= '0;
            gmii_txd <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                xl_switch_pkg::TX_IDLE: begin
                    gmii_txd <= '0;
                    gmii_tx_en <= 1'b0;
                    if (in_valid) begin
                        // first preamble byte goes out right away
                        gmii_txd <= xl_switch_pkg::ETH_PREAMBLE;
                        gmii_tx_en <= 1'b1;
                        cnt <= cnt_t'(xl_switch_pkg::PREAMBLE_LEN - 1);
                        state <= xl_switch_pkg::TX_PREAMBLE;
                    end
                end
                xl_switch_pkg::TX_PREAMBLE: begin
                    // cnt is preamble bytes still to send
                    gmii_txd <= xl_switch_pkg::ETH_PREAMBLE;
                    cnt <= cnt - 1'b1;
                    if (cnt == 1) begin
                        state <= xl_switch_pkg::TX_SFD;
                    end
                end
                xl_switch_pkg::TX_SFD: begin
                    gmii_txd <= xl_switch_pkg::ETH_SFD;
                    state <= xl_switch_pkg::TX_DATA;
                end
                xl_switch_pkg::TX_DATA: begin
                    gmii_txd <= in_data;
                    gmii_tx_en <= in_valid;
                    if (in_valid && in_last) begin
                        cnt <= cnt_t'(xl_switch_pkg::IFG_CYCLES - 1);
                        state <= xl_switch_pkg::TX_IFG;
                    end
                end
                xl_switch_pkg::TX_IFG: begin
                    // line idle for the inter-frame gap
                    gmii_txd <= '0;
                    gmii_tx_en <= 1'b0;
                    cnt <= cnt - 1'b1;
                    if (cnt == 0) begin
                        state <= xl_switch_pkg::TX_IDLE;
                    end
                end
                default: state <= xl_switch_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/cross_layer_switch.sv ====
`timescale 1ns/1ps

module cross_layer_switch (
    input  logic                        clk_int,
    input  logic                        rst_int,
    input  xl_switch_pkg::byte_t        ps_gmii_txd,
    input  logic                        ps_gmii_tx_en,
    input  logic                        ps_gmii_tx_er,
    input  xl_switch_pkg::byte_t        cs_data,
    input  logic                        cs_valid,
    output logic                        cs_ready,
    input  logic                        cs_last,
    input  logic                        cs_user,
    output xl_switch_pkg::byte_t        phy_gmii_txd,
    output logic                        phy_gmii_tx_en,
    output logic                        ps_fifo_overflow,
    output logic                        ps_fifo_bad_frame,
    output logic                        ps_fifo_good_frame,
    output logic                        cs_fifo_overflow,
    output logic                        cs_fifo_bad_frame,
    output logic                        cs_fifo_good_frame,
    output xl_switch_pkg::frame_count_t ps_tx_frame_count,
    output xl_switch_pkg::frame_count_t cs_tx_frame_count
);

    // processor gmii turned into a stream, no ready on this hop
    xl_switch_pkg::byte_t ps_rx_data;
    logic ps_rx_valid;
    logic ps_rx_last;
    logic ps_rx_user;

    // fifo outputs into the arbiter
    xl_switch_pkg::byte_t ps_q_data;
    logic ps_q_valid;
    logic ps_q_ready;
    logic ps_q_last;
    xl_switch_pkg::byte_t cs_q_data;
    logic cs_q_valid;
    logic cs_q_ready;
    logic cs_q_last;

    // arbiter to transmitter
    xl_switch_pkg::byte_t arb_data;
    logic arb_valid;
    logic arb_ready;
    logic arb_last;

    gmii_frame_rx i_gmii_frame_rx (
        .clk_int    (clk_int),
        .rst_int    (rst_int),
        .gmii_rxd   (ps_gmii_txd),
        .gmii_rx_dv (ps_gmii_tx_en),
        .gmii_rx_er (ps_gmii_tx_er),
        .data       (ps_rx_data),
        .valid      (ps_rx_valid),
        .last       (ps_rx_last),
        .user       (ps_rx_user)
    );

    // processor cannot be stalled
    frame_fifo #(
        .DROP_WHEN_FULL (1'b1)
    ) ps_fifo (
        .clk_int    (clk_int),
        .rst_int    (rst_int),
        .in_data    (ps_rx_data),
        .in_valid   (ps_rx_valid),
        .in_ready   (),
        .in_last    (ps_rx_last),
        .in_user    (ps_rx_user),
        .out_data   (ps_q_data),
        .out_valid  (ps_q_valid),
        .out_ready  (ps_q_ready),
        .out_last   (ps_q_last),
        .overflow   (ps_fifo_overflow),
        .bad_frame  (ps_fifo_bad_frame),
        .good_frame (ps_fifo_good_frame)
    );

    frame_fifo #(
        .DROP_WHEN_FULL (1'b0)
    ) cs_fifo (
        .clk_int    (clk_int),
        .rst_int    (rst_int),
        .in_data    (cs_data),
        .in_valid   (cs_valid),
        .in_ready   (cs_ready),
        .in_last    (cs_last),
        .in_user    (cs_user),
        .out_data   (cs_q_data),
        .out_valid  (cs_q_valid),
        .out_ready  (cs_q_ready),
        .out_last   (cs_q_last),
        .overflow   (cs_fifo_overflow),
        .bad_frame  (cs_fifo_bad_frame),
        .good_frame (cs_fifo_good_frame)
    );

    frame_arbiter i_frame_arbiter (
        .clk_int        (clk_int),
        .rst_int        (rst_int),
        .ps_data        (ps_q_data),
        .ps_valid       (ps_q_valid),
        .ps_ready       (ps_q_ready),
        .ps_last        (ps_q_last),
        .cs_data        (cs_q_data),
        .cs_valid       (cs_q_valid),
        .cs_ready       (cs_q_ready),
        .cs_last        (cs_q_last),
        .out_data       (arb_data),
        .out_valid      (arb_valid),
        .out_ready      (arb_ready),
        .out_last       (arb_last),
        .ps_frame_count (ps_tx_frame_count),
        .cs_frame_count (cs_tx_frame_count)
    );

    gmii_frame_tx i_gmii_frame_tx (
        .clk_int    (clk_int),
        .rst_int    (rst_int),
        .in_data    (arb_data),
        .in_valid   (arb_valid),
        .in_ready   (arb_ready),
        .in_last    (arb_last),
        .gmii_txd   (phy_gmii_txd),
        .gmii_tx_en (phy_gmii_tx_en)
    );

endmodule

// ==== tb/tb_cross_layer_switch.sv ====
`timescale 1ns/1ps

module tb_cross_layer_switch;

    // stimulus sizes and limits
    localparam int PS_FRAMES = 24;
    localparam int CS_FRAMES = 32;
    localparam int MAX_STORED = 64;
    localparam int OVERSIZE_LEN = 300;
    localparam int READY_TIMEOUT = 4000;
    localparam int DRAIN_TIMEOUT = 8000;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    // payload byte 0 names the source
    localparam xl_switch_pkg::byte_t PS_TAG = 8'hA5;
    localparam xl_switch_pkg::byte_t CS_TAG = 8'h3C;

    logic clk_int;
    logic rst_int;
    xl_switch_pkg::byte_t ps_gmii_txd;
    logic ps_gmii_tx_en;
    logic ps_gmii_tx_er;
    xl_switch_pkg::byte_t cs_data;
    logic cs_valid;
    logic cs_ready;
    logic cs_last;
    logic cs_user;
    xl_switch_pkg::byte_t phy_gmii_txd;
    logic phy_gmii_tx_en;
    logic ps_fifo_overflow;
    logic ps_fifo_bad_frame;
    logic ps_fifo_good_frame;
    logic cs_fifo_overflow;
    logic cs_fifo_bad_frame;
    logic cs_fifo_good_frame;
    xl_switch_pkg::frame_count_t ps_tx_frame_count;
    xl_switch_pkg::frame_count_t cs_tx_frame_count;

    logic [31:0] lfsr;

    // reference model with payloads by frame id and one id queue per source
    xl_switch_pkg::byte_t frame_mem [256][MAX_STORED];
    int frame_len [256];
    int frame_cnt;
    int ps_q[$];
    int cs_q[$];
    int ps_exp_total;
    int cs_exp_total;
    int ps_bad_exp;
    int cs_bad_exp;
    int cs_ovf_exp;

    // status pulse counters seen on the dut
    int ps_good;
    int cs_good;
    int prev_ps_good;
    int prev_cs_good;
    int ps_bad;
    int cs_bad;
    int ps_ovf;
    int cs_ovf;

    // output monitor state
    xl_switch_pkg::byte_t burst [512];
    int burst_len;
    bit in_burst;
    int idle_run;
    int ps_out;
    int cs_out;
    int out_frames;
    xl_switch_pkg::source_t last_src;
    // frames still waiting in each fifo when the arbiter last chose
    int ps_pend_snap;
    int cs_pend_snap;

    cross_layer_switch i_cross_layer_switch (
        .clk_int            (clk_int),
        .rst_int            (rst_int),
        .ps_gmii_txd        (ps_gmii_txd),
        .ps_gmii_tx_en      (ps_gmii_tx_en),
        .ps_gmii_tx_er      (ps_gmii_tx_er),
        .cs_data            (cs_data),
        .cs_valid           (cs_valid),
        .cs_ready           (cs_ready),
        .cs_last            (cs_last),
        .cs_user            (cs_user),
        .phy_gmii_txd       (phy_gmii_txd),
        .phy_gmii_tx_en     (phy_gmii_tx_en),
        .ps_fifo_overflow   (ps_fifo_overflow),
        .ps_fifo_bad_frame  (ps_fifo_bad_frame),
        .ps_fifo_good_frame (ps_fifo_good_frame),
        .cs_fifo_overflow   (cs_fifo_overflow),
        .cs_fifo_bad_frame  (cs_fifo_bad_frame),
        .cs_fifo_good_frame (cs_fifo_good_frame),
        .ps_tx_frame_count  (ps_tx_frame_count),
        .cs_tx_frame_count  (cs_tx_frame_count)
    );

    // 10 ns clock
    always #5 clk_int = ~clk_int;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // preamble, sfd, payload, then idle line
    task automatic send_ps_frame(input int len, input bit err, input int seq);
        int id;
        int k;
        int err_pos;
        int gap;
        id = frame_cnt;
        frame_cnt++;
        frame_len[id] = len;
        frame_mem[id][0] = PS_TAG;
        frame_mem[id][1] = seq[7:0];
        for (k = 2; k < len; k++) begin
            frame_mem[id][k] = 8'(rand_bits(8));
        end
        err_pos = int'(rand_bits(5)) % len;
        // tx_er anywhere kills the frame
        if (err) begin
            ps_bad_exp++;
        end else begin
            ps_q.push_back(id);
            ps_exp_total++;
        end
        for (k = 0; k < 8; k++) begin
            @(posedge clk_int);
            #1;
            ps_gmii_tx_en = 1'b1;
            ps_gmii_tx_er = 1'b0;
            ps_gmii_txd = (k < 7) ? xl_switch_pkg::ETH_PREAMBLE : xl_switch_pkg::ETH_SFD;
        end
        for (k = 0; k < len; k++) begin
            @(posedge clk_int);
            #1;
            ps_gmii_txd = frame_mem[id][k];
            ps_gmii_tx_er = err && (k == err_pos);
        end
        @(posedge clk_int);
        #1;
        ps_gmii_tx_en = 1'b0;
        ps_gmii_tx_er = 1'b0;
        ps_gmii_txd = '0;
        // long gap keeps the ps fifo from filling
        gap = xl_switch_pkg::IFG_CYCLES + 64 + int'(rand_bits(6));
        repeat (gap - 1) @(posedge clk_int);
    endtask

    // one stream frame with each byte held until cs_ready
    task automatic send_cs_frame(input int len, input bit bad, input int seq);
        int id;
        int k;
        int waited;
        xl_switch_pkg::byte_t b;
        id = 0;
        if (len <= MAX_STORED) begin
            id = frame_cnt;
            frame_cnt++;
            frame_len[id] = len;
        end
        @(posedge clk_int);
        #1;
        for (k = 0; k < len; k++) begin
            if (k == 0) begin
                b = CS_TAG;
            end else if (k == 1) begin
                b = seq[7:0];
            end else begin
                b = 8'(rand_bits(8));
            end
            if (len <= MAX_STORED) begin
                frame_mem[id][k] = b;
            end
            cs_data = b;
            cs_valid = 1'b1;
            cs_last = (k == len - 1);
            cs_user = bad && (k == len - 1);
            // ready is stable from the falling edge on
            waited = 0;
            @(negedge clk_int);
            while (!cs_ready) begin
                waited++;
                assert (waited < READY_TIMEOUT)
                    else fail_now("timeout waiting for cs_ready");
                @(negedge clk_int);
            end
            @(posedge clk_int);
            #1;
        end
        cs_valid = 1'b0;
        cs_last = 1'b0;
        cs_user = 1'b0;
        if (len > xl_switch_pkg::FIFO_DEPTH) begin
            cs_ovf_exp++;
        end else if (bad) begin
            cs_bad_exp++;
        end else begin
            cs_q.push_back(id);
            cs_exp_total++;
        end
    endtask

    task automatic run_ps();
        int n;
        int len;
        bit err;
        for (n = 0; n < PS_FRAMES; n++) begin
            len = 2 + int'(rand_bits(5));
            // about one in eight frames carries tx_er, one of them always
            err = (rand_bits(3) == 32'd0) || (n == PS_FRAMES / 2);
            send_ps_frame(len, err, n);
        end
    endtask

    task automatic run_cs();
        int n;
        int sel;
        for (n = 0; n < CS_FRAMES; n++) begin
            sel = int'(rand_bits(4));
            // at least one oversize frame with good frames after it
            if (sel == 0 || n == CS_FRAMES / 2) begin
                send_cs_frame(OVERSIZE_LEN, 1'b0, n);
            end else if (sel < 3) begin
                send_cs_frame(2 + int'(rand_bits(5)), 1'b1, n);
            end else begin
                send_cs_frame(2 + int'(rand_bits(5)), 1'b0, n);
            end
            repeat (int'(rand_bits(5))) @(posedge clk_int);
        end
    endtask

    // strip preamble and sfd, then match against the tagged source queue
    task automatic check_burst();
        int k;
        int id;
        xl_switch_pkg::source_t src;
        id = 0;
        src = xl_switch_pkg::SRC_PS;
        assert (burst_len >= 10)
            else fail_now($sformatf("burst of %0d bytes too short at %0t", burst_len, $time));
        for (k = 0; k < 7; k++) begin
            assert (burst[k] == xl_switch_pkg::ETH_PREAMBLE)
                else fail_now($sformatf("ERROR t=%0t phy_gmii_txd preamble expected %h got %h",
                    $time, xl_switch_pkg::ETH_PREAMBLE, burst[k]));
        end
        assert (burst[7] == xl_switch_pkg::ETH_SFD)
            else fail_now($sformatf("ERROR t=%0t phy_gmii_txd sfd expected %h got %h",
                $time, xl_switch_pkg::ETH_SFD, burst[7]));
        assert (burst[8] == PS_TAG || burst[8] == CS_TAG)
            else fail_now($sformatf("ERROR t=%0t phy_gmii_txd tag expected %h or %h got %h",
                $time, PS_TAG, CS_TAG, burst[8]));
        if (burst[8] == CS_TAG) begin
            src = xl_switch_pkg::SRC_CS;
            assert (cs_q.size() > 0)
                else fail_now("cs frame on the phy side while none was expected");
            id = cs_q.pop_front();
        end else begin
            assert (ps_q.size() > 0)
                else fail_now("ps frame on the phy side while none was expected");
            id = ps_q.pop_front();
        end
        assert (burst_len - 8 == frame_len[id])
            else fail_now($sformatf("ERROR t=%0t phy_gmii_txd payload length expected %0d got %0d",
                $time, frame_len[id], burst_len - 8));
        for (k = 0; k < frame_len[id]; k++) begin
            assert (burst[8 + k] == frame_mem[id][k])
                else fail_now($sformatf("ERROR t=%0t phy_gmii_txd byte %0d expected %h got %h",
                    $time, k, frame_mem[id][k], burst[8 + k]));
        end
        // same source twice only if the other fifo was empty at the choice
        if (out_frames > 0 && src == last_src) begin
            assert ((src == xl_switch_pkg::SRC_PS) ? cs_pend_snap == 0 : ps_pend_snap == 0)
                else fail_now("arbiter served one source twice while the other had a frame");
        end
        if (src == xl_switch_pkg::SRC_PS) begin
            ps_out++;
        end else begin
            cs_out++;
        end
        out_frames++;
        last_src = src;
        // commits visible to the arbiter on its next choice
        ps_pend_snap = prev_ps_good - ps_out;
        cs_pend_snap = prev_cs_good - cs_out;
    endtask

    // dut outputs are registered so sample them mid cycle
    always @(negedge clk_int) begin
        if (!rst_int) begin
            prev_ps_good = ps_good;
            prev_cs_good = cs_good;
            ps_good += int'(ps_fifo_good_frame);
            cs_good += int'(cs_fifo_good_frame);
            ps_bad += int'(ps_fifo_bad_frame);
            cs_bad += int'(cs_fifo_bad_frame);
            ps_ovf += int'(ps_fifo_overflow);
            cs_ovf += int'(cs_fifo_overflow);
            if (phy_gmii_tx_en) begin
                if (!in_burst) begin
                    // gap only counts between two bursts
                    if (out_frames > 0) begin
                        assert (idle_run >= xl_switch_pkg::IFG_CYCLES)
                            else fail_now($sformatf(
                                "ERROR t=%0t phy_gmii_tx_en idle cycles expected %0d got %0d",
                                $time, xl_switch_pkg::IFG_CYCLES, idle_run));
                    end
                    in_burst = 1'b1;
                    burst_len = 0;
                end
                assert (burst_len < 512)
                    else fail_now("burst on the phy side longer than any frame sent");
                burst[burst_len] = phy_gmii_txd;
                burst_len++;
            end else begin
                if (in_burst) begin
                    in_burst = 1'b0;
                    check_burst();
                    idle_run = 0;
                end
                idle_run++;
            end
        end
    end

    initial begin
        int waited;
        clk_int = 1'b0;
        rst_int = 1'b1;
        ps_gmii_txd = '0;
        ps_gmii_tx_en = 1'b0;
        ps_gmii_tx_er = 1'b0;
        cs_data = '0;
        cs_valid = 1'b0;
        cs_last = 1'b0;
        cs_user = 1'b0;
        lfsr = 32'h1288;
        frame_cnt = 0;
        ps_exp_total = 0;
        cs_exp_total = 0;
        ps_bad_exp = 0;
        cs_bad_exp = 0;
        cs_ovf_exp = 0;
        ps_good = 0;
        cs_good = 0;
        prev_ps_good = 0;
        prev_cs_good = 0;
        ps_bad = 0;
        cs_bad = 0;
        ps_ovf = 0;
        cs_ovf = 0;
        burst_len = 0;
        in_burst = 1'b0;
        idle_run = 0;
        ps_out = 0;
        cs_out = 0;
        out_frames = 0;
        last_src = xl_switch_pkg::SRC_CS;
        ps_pend_snap = 0;
        cs_pend_snap = 0;
        repeat (4) @(posedge clk_int);
        #1;
        rst_int = 1'b0;
        fork
            run_ps();
            run_cs();
        join
        // let the fifos drain onto the phy side
        waited = 0;
        while (ps_q.size() != 0 || cs_q.size() != 0 || in_burst) begin
            waited++;
            assert (waited < DRAIN_TIMEOUT)
                else fail_now("timeout waiting for expected frames on the phy side");
            @(posedge clk_int);
        end
        repeat (4) @(posedge clk_int);
        assert (int'(ps_tx_frame_count) == ps_exp_total)
            else fail_now($sformatf("ERROR t=%0t ps_tx_frame_count expected %0d got %0d",
                $time, ps_exp_total, ps_tx_frame_count));
        assert (int'(cs_tx_frame_count) == cs_exp_total)
            else fail_now($sformatf("ERROR t=%0t cs_tx_frame_count expected %0d got %0d",
                $time, cs_exp_total, cs_tx_frame_count));
        assert (ps_good == ps_exp_total && cs_good == cs_exp_total)
            else fail_now($sformatf("ERROR t=%0t good_frame pulses expected %0d/%0d got %0d/%0d",
                $time, ps_exp_total, cs_exp_total, ps_good, cs_good));
        assert (ps_bad == ps_bad_exp && cs_bad == cs_bad_exp)
            else fail_now($sformatf("ERROR t=%0t bad_frame pulses expected %0d/%0d got %0d/%0d",
                $time, ps_bad_exp, cs_bad_exp, ps_bad, cs_bad));
        assert (ps_ovf == 0 && cs_ovf == cs_ovf_exp)
            else fail_now($sformatf("ERROR t=%0t overflow pulses expected 0/%0d got %0d/%0d",
                $time, cs_ovf_exp, ps_ovf, cs_ovf));
        $display("sim passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/xl_switch_pkg.sv
verilog/gmii_frame_rx.sv
verilog/frame_fifo.sv
verilog/frame_arbiter.sv
verilog/gmii_frame_tx.sv
verilog/cross_layer_switch.sv
tb/tb_cross_layer_switch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cross-layer switch testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_cross_layer_switch \
    -f vlog.f \
    -o tb_cross_layer_switch
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cross_layer_switch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
